//--- hw/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define RESET_PC    32'hBFC00000

// primary opcodes
`define OP_RTYPE    6'b000000
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_ADDIU    6'b001001
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

// function field, R-type only
`define FUNCT_ADDU  6'b100001
`define FUNCT_SUBU  6'b100011
`define FUNCT_AND   6'b100100
`define FUNCT_OR    6'b100101
`define FUNCT_XOR   6'b100110
`define FUNCT_SLT   6'b101010

`endif

//--- hw/mipsPkg.sv
`default_nettype none

`include "mips_defs.svh"

package mipsPkg;

    typedef logic [`WORD_W-1:0] word;         // data or address
    typedef logic [`REG_ADDR_W-1:0] regAddr;  // gpr number

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI    // imm into upper half
    } aluOp;

endpackage

`default_nettype wire

//--- hw/pipeIf.sv
`timescale 1ns/1ns
`default_nettype none

interface fetchDecodeIf;
    import mipsPkg::*;

    word    pcD;
    word    pcPlus4D;
    word    instrD;
    regAddr rsD;   // source fields, back to hazard unit
    regAddr rtD;

    modport fetch (output pcD, pcPlus4D, instrD);
    modport decode (input pcD, pcPlus4D, instrD, output rsD, rtD);
    modport monitor (input rsD, rtD);
endinterface

interface decodeExecIf;
    import mipsPkg::*;

    word    pcE;
    word    pcPlus4E;
    regAddr rs, rt, dest;
    word    rd1, rd2, imm;
    aluOp   aluCtl;
    logic   useImm;
    logic   regWriteEn, memRead, memWrite;
    logic   isBranch, branchNe;

    modport decode (output pcE, pcPlus4E, rs, rt, dest, rd1, rd2, imm, aluCtl,
                    useImm, regWriteEn, memRead, memWrite, isBranch, branchNe);
    modport exec (input pcE, pcPlus4E, rs, rt, dest, rd1, rd2, imm, aluCtl,
                  useImm, regWriteEn, memRead, memWrite, isBranch, branchNe);
    modport monitor (input rs, rt, dest, memRead);
endinterface

interface execMemIf;
    import mipsPkg::*;

    word    pcM;
    word    aluOut;
    word    storeData;
    regAddr destM;
    logic   regWriteEnM, memReadM, memWriteM;

    modport exec (output pcM, aluOut, storeData, destM, regWriteEnM, memReadM, memWriteM);
    modport mem (input pcM, aluOut, storeData, destM, regWriteEnM, memReadM, memWriteM);
    modport monitor (input destM, regWriteEnM);
endinterface

interface hazardIf;
    logic       stallFront;  // F and D hold
    logic       freeze;      // whole pipe holds
    logic       flushD, flushE;
    logic [1:0] forwardA, forwardB;  // 0 reg, 1 mem, 2 wb

    modport control (output stallFront, freeze, flushD, flushE, forwardA, forwardB);
    modport stage (input stallFront, freeze, flushD, flushE, forwardA, forwardB);
endinterface

`default_nettype wire

//--- hw/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module fetchStage (
    input  wire                clk,
    input  wire                reset,
    output mipsPkg::word       pcF,
    input  wire mipsPkg::word  instrF,
    input  wire                branchTaken,
    input  wire mipsPkg::word  branchTarget,
    fetchDecodeIf.fetch        fd,
    hazardIf.stage             hz
);
    import mipsPkg::*;

    word pcPlus4F;
    word pcNext;
    logic advance;

    assign pcPlus4F = pcF + 32'd4;
    assign pcNext   = branchTaken ? branchTarget : pcPlus4F;
    assign advance  = !hz.freeze && !hz.stallFront;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= `RESET_PC;
        end else if (advance) begin
            pcF <= pcNext;
        end
    end

    // F/D register, zero word is a nop
    always_ff @(posedge clk) begin
        if (reset) begin
            fd.instrD <= '0;
        end else if (!hz.freeze) begin
            if (hz.flushD) begin
                fd.instrD <= '0;      // drops the slot after the delay slot
            end else if (!hz.stallFront) begin
                fd.instrD <= instrF;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            fd.pcD      <= pcF;
            fd.pcPlus4D <= pcPlus4F;
        end
    end

    // targets come from execute, must stay aligned
    pcAligned: assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  wire                   clk,
    input  wire                   reset,
    input  wire mipsPkg::regAddr  ra1,
    input  wire mipsPkg::regAddr  ra2,
    output mipsPkg::word          rd1,
    output mipsPkg::word          rd2,
    input  wire                   wbEn,
    input  wire mipsPkg::regAddr  wbAddr,
    input  wire mipsPkg::word     wbData
);
    import mipsPkg::*;

    word regs [0:31];

    // write-through so decode sees the value retiring this cycle
    function automatic word readReg(regAddr ra);
        if (ra == '0) begin
            return '0;
        end else if (wbEn && ra == wbAddr) begin
            return wbData;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk) begin
        if (wbEn && !reset && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    assign rd1 = readReg(ra1);
    assign rd2 = readReg(ra2);

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module decodeStage (
    input  wire                clk,
    input  wire                reset,
    fetchDecodeIf.decode       fd,
    decodeExecIf.decode        de,
    hazardIf.stage             hz,
    output mipsPkg::regAddr    ra1,
    output mipsPkg::regAddr    ra2,
    input  wire mipsPkg::word  rd1,
    input  wire mipsPkg::word  rd2
);
    import mipsPkg::*;

    logic [5:0] opcode, funct;
    regAddr rdField, destD;
    aluOp aluCtlD;
    logic useImmD, zeroExtD, regWriteEnD, memReadD, memWriteD, isBranchD, branchNeD;
    word immD;

    assign opcode   = fd.instrD[31:26];
    assign funct    = fd.instrD[5:0];
    assign rdField  = fd.instrD[15:11];
    assign fd.rsD   = fd.instrD[25:21];
    assign fd.rtD   = fd.instrD[20:16];
    assign ra1      = fd.rsD;
    assign ra2      = fd.rtD;

    always_comb begin
        aluCtlD = ALU_ADD;
        {useImmD, zeroExtD, regWriteEnD, memReadD, memWriteD, isBranchD, branchNeD} = '0;
        destD = '0;    // no write unless set below
        case (opcode)
            `OP_RTYPE: begin
                regWriteEnD = 1'b1;
                destD = rdField;
                case (funct)
                    `FUNCT_ADDU: aluCtlD = ALU_ADD;
                    `FUNCT_SUBU: aluCtlD = ALU_SUB;
                    `FUNCT_AND:  aluCtlD = ALU_AND;
                    `FUNCT_OR:   aluCtlD = ALU_OR;
                    `FUNCT_XOR:  aluCtlD = ALU_XOR;
                    `FUNCT_SLT:  aluCtlD = ALU_SLT;
                    default: begin
                        regWriteEnD = 1'b0;   // sll r0 etc, nop
                        destD = '0;
                    end
                endcase
            end
            `OP_ADDIU: {useImmD, regWriteEnD, destD} = {2'b11, fd.rtD};
            `OP_ORI: begin
                aluCtlD = ALU_OR;
                {useImmD, zeroExtD, regWriteEnD, destD} = {3'b111, fd.rtD};
            end
            `OP_LUI: begin
                aluCtlD = ALU_LUI;
                {useImmD, regWriteEnD, destD} = {2'b11, fd.rtD};
            end
            `OP_LW: {useImmD, memReadD, regWriteEnD, destD} = {3'b111, fd.rtD};
            `OP_SW: {useImmD, memWriteD} = 2'b11;
            `OP_BEQ: isBranchD = 1'b1;
            `OP_BNE: {isBranchD, branchNeD} = 2'b11;
            default: ;
        endcase
    end

    assign immD = zeroExtD ? {16'b0, fd.instrD[15:0]} : {{16{fd.instrD[15]}}, fd.instrD[15:0]};

    // D/E control, bubble on load-use
    always_ff @(posedge clk) begin
        if (reset || hz.flushE) begin
            {de.regWriteEn, de.memRead, de.memWrite, de.isBranch} <= '0;
            de.dest <= '0;
            de.rs   <= '0;    // keeps forwarding quiet for the bubble
            de.rt   <= '0;
        end else if (!hz.freeze && !hz.stallFront) begin
            {de.regWriteEn, de.memRead, de.memWrite, de.isBranch} <=
                {regWriteEnD, memReadD, memWriteD, isBranchD};
            de.dest <= destD;
            de.rs   <= fd.rsD;
            de.rt   <= fd.rtD;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.freeze && !hz.stallFront) begin
            de.pcE      <= fd.pcD;
            de.pcPlus4E <= fd.pcPlus4D;
            de.rd1      <= rd1;
            de.rd2      <= rd2;
            de.imm      <= immD;
            de.aluCtl   <= aluCtlD;
            de.useImm   <= useImmD;
            de.branchNe <= branchNeD;
        end
    end

endmodule

`default_nettype wire

//--- hw/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  wire                clk,
    input  wire                reset,
    decodeExecIf.exec          de,
    execMemIf.exec             em,
    hazardIf.stage             hz,
    input  wire mipsPkg::word  aluOutM,
    input  wire mipsPkg::word  resultW,
    output logic               branchTaken,
    output mipsPkg::word       branchTarget
);
    import mipsPkg::*;

    word rsVal, rtVal;
    word srcB;
    word aluResult;

    function automatic word fwdMux(logic [1:0] sel, word regVal);
        case (sel)
            2'd1:    return aluOutM;
            2'd2:    return resultW;
            default: return regVal;
        endcase
    endfunction

    assign rsVal = fwdMux(hz.forwardA, de.rd1);
    assign rtVal = fwdMux(hz.forwardB, de.rd2);
    assign srcB  = de.useImm ? de.imm : rtVal;

    always_comb begin
        case (de.aluCtl)
            ALU_ADD: aluResult = rsVal + srcB;
            ALU_SUB: aluResult = rsVal - srcB;
            ALU_AND: aluResult = rsVal & srcB;
            ALU_OR:  aluResult = rsVal | srcB;
            ALU_XOR: aluResult = rsVal ^ srcB;
            ALU_SLT: aluResult = ($signed(rsVal) < $signed(srcB)) ? 32'd1 : 32'd0;
            ALU_LUI: aluResult = {srcB[15:0], 16'b0};
            default: aluResult = '0;
        endcase
    end

    // beq/bne on forwarded operands
    assign branchTaken  = de.isBranch && ((rsVal == rtVal) ^ de.branchNe);
    assign branchTarget = de.pcPlus4E + {de.imm[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            {em.regWriteEnM, em.memReadM, em.memWriteM} <= '0;
            em.destM <= '0;
        end else if (!hz.freeze) begin
            {em.regWriteEnM, em.memReadM, em.memWriteM} <=
                {de.regWriteEn, de.memRead, de.memWrite};
            em.destM <= de.dest;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.freeze) begin
            em.aluOut    <= aluResult;
            em.storeData <= rtVal;
            em.pcM       <= de.pcE;
        end
    end

    // a load in M has no data yet, load-use stall must have covered it
    noLoadForward: assert property (@(posedge clk) disable iff (reset)
        em.memReadM |-> (hz.forwardA != 2'd1 && hz.forwardB != 2'd1));

endmodule

`default_nettype wire

//--- hw/memWbStage.sv
`timescale 1ns/1ns
`default_nettype none

module memWbStage (
    input  wire                clk,
    input  wire                reset,
    execMemIf.mem              em,
    hazardIf.stage             hz,
    output logic               memEn,
    output logic               memWen,
    output mipsPkg::word       memAddr,
    output mipsPkg::word       memWdata,
    input  wire mipsPkg::word  memRdata,
    output mipsPkg::word       aluOutM,
    output mipsPkg::word       resultW,
    output logic               wbEn,
    output mipsPkg::regAddr    wbAddr,
    output mipsPkg::word       debugWbPc,
    output logic               debugWbRfWen,
    output mipsPkg::regAddr    debugWbRfWnum,
    output mipsPkg::word       debugWbRfWdata
);
    import mipsPkg::*;

    word resultM;
    word pcW;
    logic wFresh;    // W just loaded from M

    assign memEn    = (em.memReadM | em.memWriteM) & ~hz.freeze;  // one access per store
    assign memWen   = em.memWriteM & ~hz.freeze;
    assign memAddr  = em.aluOut;
    assign memWdata = em.storeData;
    assign aluOutM  = em.aluOut;
    assign resultM  = em.memReadM ? memRdata : em.aluOut;

    // W keeps its value through a freeze so the W forward path stays good,
    // the rewrite to the register file is the same value
    always_ff @(posedge clk) begin
        if (reset) begin
            wbEn   <= 1'b0;
            wFresh <= 1'b0;
        end else begin
            wFresh <= ~hz.freeze;
            if (!hz.freeze) begin
                wbEn <= em.regWriteEnM;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.freeze) begin
            resultW <= resultM;
            wbAddr  <= em.destM;
            pcW     <= em.pcM;
        end
    end

    assign debugWbPc      = pcW;
    assign debugWbRfWen   = wbEn & wFresh & (wbAddr != '0);  // once per instruction
    assign debugWbRfWnum  = wbAddr;
    assign debugWbRfWdata = resultW;

endmodule

`default_nettype wire

//--- hw/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
    input  wire                   clk,
    input  wire                   reset,
    hazardIf.control              hz,
    input  wire                   iCacheStall,
    fetchDecodeIf.monitor         fd,
    decodeExecIf.monitor          de,
    execMemIf.monitor             em,
    input  wire                   branchTaken,
    input  wire                   wbEn,
    input  wire mipsPkg::regAddr  wbAddr
);
    import mipsPkg::*;

    logic loadUse;

    // mem stage wins over wb
    function automatic logic [1:0] fwdSel(regAddr src);
        if (em.regWriteEnM && em.destM != '0 && em.destM == src) begin
            return 2'd1;
        end else if (wbEn && wbAddr != '0 && wbAddr == src) begin
            return 2'd2;
        end
        return 2'd0;
    endfunction

    assign loadUse = de.memRead && de.dest != '0 && (de.dest == fd.rsD || de.dest == fd.rtD);

    assign hz.freeze     = iCacheStall;
    assign hz.stallFront = loadUse;
    assign hz.flushE     = loadUse & ~iCacheStall;
    assign hz.flushD     = branchTaken & ~iCacheStall;   // freeze beats redirect
    assign hz.forwardA   = fwdSel(de.rs);
    assign hz.forwardB   = fwdSel(de.rt);

    // E holds either a load or a branch, never both
    stallVsFlush: assert property (@(posedge clk) disable iff (reset)
        !(hz.stallFront && hz.flushD));

endmodule

`default_nettype wire

//--- hw/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore (
    input  wire                clk,
    input  wire                reset,
    output mipsPkg::word       pcF,
    input  wire mipsPkg::word  instrF,
    input  wire                iCacheStall,
    output logic               memEn,
    output logic               memWen,
    output mipsPkg::word       memAddr,
    output mipsPkg::word       memWdata,
    input  wire mipsPkg::word  memRdata,
    output mipsPkg::word       debugWbPc,
    output logic               debugWbRfWen,
    output mipsPkg::regAddr    debugWbRfWnum,
    output mipsPkg::word       debugWbRfWdata
);
    import mipsPkg::*;

    logic   branchTaken;
    word    branchTarget;
    word    aluOutM, resultW;
    logic   wbEn;
    regAddr wbAddr;
    regAddr ra1, ra2;
    word    rd1, rd2;

    fetchDecodeIf fdIf ();
    decodeExecIf  deIf ();
    execMemIf     emIf ();
    hazardIf      hzIf ();

    fetchStage fetch0 (
        .clk, .reset, .pcF, .instrF, .branchTaken, .branchTarget,
        .fd(fdIf), .hz(hzIf)
    );

    decodeStage decode0 (
        .clk, .reset, .fd(fdIf), .de(deIf), .hz(hzIf),
        .ra1, .ra2, .rd1, .rd2
    );

    regFile regs0 (
        .clk, .reset, .ra1, .ra2, .rd1, .rd2,
        .wbEn, .wbAddr, .wbData(resultW)
    );

    executeStage exec0 (
        .clk, .reset, .de(deIf), .em(emIf), .hz(hzIf),
        .aluOutM, .resultW, .branchTaken, .branchTarget
    );

    memWbStage memWb0 (
        .clk, .reset, .em(emIf), .hz(hzIf),
        .memEn, .memWen, .memAddr, .memWdata, .memRdata,
        .aluOutM, .resultW, .wbEn, .wbAddr,
        .debugWbPc, .debugWbRfWen, .debugWbRfWnum, .debugWbRfWdata
    );

    hazardUnit hazard0 (
        .clk, .reset, .hz(hzIf), .iCacheStall,
        .fd(fdIf), .de(deIf), .em(emIf),
        .branchTaken, .wbEn, .wbAddr
    );

endmodule

`default_nettype wire

//--- bench/coreTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module coreTb;
    import mipsPkg::*;

    localparam int ImemWords = 64;
    localparam int MaxTrace = 64;
    localparam int DrainCycles = 8;    // quiet window after the last write-back

    logic clk = 1'b0;
    logic reset;
    logic iCacheStall;
    word pcF, instrF;
    logic memEn, memWen;
    word memAddr, memWdata, memRdata;
    word debugWbPc;
    logic debugWbRfWen;
    regAddr debugWbRfWnum;
    word debugWbRfWdata;

    word imem [0:ImemWords-1];
    word dmem [0:63];
    word pcOff;

    word expPc [0:MaxTrace-1];
    regAddr expReg [0:MaxTrace-1];
    word expData [0:MaxTrace-1];
    int expCount = 0;
    int progLen = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    int seed = 7;
    int timeoutLimit = 0;
    bit timedOut = 1'b0;

    mipsCore uut (
        .clk, .reset, .pcF, .instrF, .iCacheStall,
        .memEn, .memWen, .memAddr, .memWdata, .memRdata,
        .debugWbPc, .debugWbRfWen, .debugWbRfWnum, .debugWbRfWdata
    );

    always #2 clk = ~clk;

    // instruction rom, nops past the program
    assign pcOff  = pcF - `RESET_PC;
    assign instrF = (pcOff < ImemWords * 4) ? imem[pcOff[7:2]] : '0;

    assign memRdata = memEn ? dmem[memAddr[7:2]] : '0;    // no data unless enabled

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= '0;
            end
        end else if (memEn && memWen) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    task automatic readGolden();
        int fd;
        int c;
        int n;
        word a;
        word b;
        word r;
        word off;
        for (int i = 0; i < ImemWords; i++) begin
            imem[i] = '0;
        end
        fd = $fopen("bench/golden_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/golden_trace.txt");
            otherErrors++;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c[7:0] == "#") begin
                while (c != -1 && c[7:0] != "\n") begin
                    c = $fgetc(fd);   // rest of a comment
                end
            end else if (c[7:0] == "P") begin
                n = $fscanf(fd, "%h %h", a, b);
                off = a - `RESET_PC;
                if (n == 2 && off < ImemWords * 4) begin
                    imem[off[7:2]] = b;
                    progLen++;
                end else begin
                    $display("bad program line in golden file near word %0d", progLen);
                    otherErrors++;
                end
            end else if (c[7:0] == "E") begin
                n = $fscanf(fd, "%h %d %h", a, r, b);
                if (n == 3 && expCount < MaxTrace) begin
                    expPc[expCount]   = a;
                    expReg[expCount]  = r[4:0];
                    expData[expCount] = b;
                    expCount++;
                end else begin
                    $display("bad trace line in golden file near entry %0d", expCount);
                    otherErrors++;
                end
            end
            if (c != -1) begin
                c = $fgetc(fd);
            end
        end
        $fclose(fd);
    endtask

    task automatic checkIdle(input string phase);
        assert (pcF == `RESET_PC && !debugWbRfWen && !memEn && !memWen) else begin
            $display("[FAIL] %0t: %s pcF=%h debugWbRfWen=%b memEn=%b memWen=%b",
                     $time, phase, pcF, debugWbRfWen, memEn, memWen);
            valueErrors++;
        end
    endtask

    task automatic compareWriteBack(input int idx);
        assert (idx < expCount) else begin
            $display("extra write-back of r%0d at %0t after the whole trace was seen",
                     debugWbRfWnum, $time);
            otherErrors++;
        end
        if (idx < expCount) begin
            assert (debugWbPc == expPc[idx] && debugWbRfWnum == expReg[idx]
                    && debugWbRfWdata == expData[idx]) else begin
                $display("[FAIL] %0t: entry %0d got pc=%h r%0d=%h, expected pc=%h r%0d=%h",
                         $time, idx, debugWbPc, debugWbRfWnum, debugWbRfWdata,
                         expPc[idx], expReg[idx], expData[idx]);
                valueErrors++;
            end
        end
    endtask

    // one reset and one pass over the program
    task automatic runPass(input bit withStall, input string name);
        int idx;
        int cycles;
        int drain;
        idx = 0;
        cycles = 0;
        drain = 0;
        reset = 1'b1;
        iCacheStall = 1'b0;
        repeat (4) begin
            @(negedge clk);
            checkIdle("in reset");
        end
        reset = 1'b0;
        #1;
        checkIdle("first cycle after reset");
        while (!timedOut && (idx < expCount || drain < DrainCycles)) begin
            @(negedge clk);
            cycles++;
            if (debugWbRfWen) begin
                compareWriteBack(idx);
                idx++;
            end
            if (idx >= expCount) begin
                drain++;
            end
            iCacheStall = withStall ? (($random(seed) & 3) == 0) : 1'b0;
            if (cycles >= timeoutLimit) begin
                timedOut = 1'b1;
            end
        end
        iCacheStall = 1'b0;
        if (timedOut) begin
            $display("timeout in %s pass after %0d cycles", name, cycles);
            otherErrors++;
        end
        assert (idx >= expCount) else begin
            $display("trace ended early in %s pass, %0d of %0d write-backs seen",
                     name, idx, expCount);
            otherErrors++;
        end
    endtask

    initial begin
        reset = 1'b1;
        iCacheStall = 1'b0;
        readGolden();
        timeoutLimit = 4 * progLen + 50;
        runPass(1'b0, "clean");
        if (!timedOut) begin
            runPass(1'b1, "random stall");
        end
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/golden_trace.txt
# P lines load the instruction memory with address and word in hex
# E lines give pc (hex), register (decimal) and data (hex) of each write-back in order
P BFC00000 3C011234
P BFC00004 34215678
P BFC00008 2402FFFD
P BFC0000C 00221823
P BFC00010 AC030008
P BFC00014 8C040008
P BFC00018 00812826
P BFC0001C 0045302A
P BFC00020 10C00005
P BFC00024 00623824
P BFC00028 14E30002
P BFC0002C 00C54025
P BFC00030 24080BAD   # squashed by the taken bne
P BFC00034 8C090008
P BFC00038 11230002
P BFC0003C 01285021
P BFC00040 340ADEAD   # squashed by the taken beq
P BFC00044 154A0003
P BFC00048 254B0002
P BFC0004C 0162602A
P BFC00050 AC0B000C
P BFC00054 8C0D000C
E BFC00000 1 12340000
E BFC00004 1 12345678
E BFC00008 2 FFFFFFFD
E BFC0000C 3 1234567B
E BFC00014 4 1234567B
E BFC00018 5 00000003
E BFC0001C 6 00000001
E BFC00024 7 12345679
E BFC0002C 8 00000003
E BFC00034 9 1234567B
E BFC0003C 10 1234567E
E BFC00048 11 12345680
E BFC0004C 12 00000000
E BFC00054 13 12345680

//--- flist.f
+incdir+hw
hw/mipsPkg.sv
hw/pipeIf.sv
hw/fetchStage.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memWbStage.sv
hw/hazardUnit.sv
hw/mipsCore.sv
bench/coreTb.sv

//--- Makefile
# Verilator build and run of the core testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module coreTb -f flist.f -o coreTbSim

run: build
	./obj_dir/coreTbSim | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert --top-module coreTb -f flist.f

clean:
	rm -rf obj_dir
